//--- verilog/rd_engine_pkg.sv
// ==============================
// Shared constants and types for the AXI4 read engine
// AXI widths are fixed here; modules pull them in by wildcard import
// ==============================
`default_nettype none

package rd_engine_pkg;

    // ==============================
    // AXI bus geometry
    // ==============================
    localparam int addr_width  = 32;
    localparam int data_width  = 64;
    localparam int id_width    = 4;
    localparam int len_width   = 8;
    // Scheduler count of beats still to read
    localparam int beats_width = 32;

    // Full-width beats, log2 of bytes per beat
    localparam logic [2:0] axi_size_code  = 3'($clog2(data_width / 8));
    localparam logic [1:0] axi_burst_incr = 2'b01;
    localparam logic [1:0] resp_okay      = 2'b00;

    // Burst size in beats, not the len-1 AXI form
    typedef logic [len_width-1:0] xfer_len_t;

    // One read address command
    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [addr_width-1:0] addr;
        xfer_len_t             len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } ar_cmd_t;

    // One read data beat, also the SRAM write word
    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [data_width-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } r_beat_t;

    // Space reservation sent ahead of the data
    typedef struct packed {
        xfer_len_t           size;
        logic [id_width-1:0] id;
    } alloc_req_t;

endpackage

`default_nettype wire

//--- verilog/rd_request_mask.sv
// ==============================
// Per-channel burst sizing and eligibility for the read engine
// Purely combinational; output feeds the round-robin arbiter
// ==============================
`timescale 1ns/1ps
`default_nettype none

module rd_request_mask
    import rd_engine_pkg::*;
#(
    parameter int num_channels = 4,
    parameter int space_width  = 8
) (
    input  wire logic [num_channels-1:0]                  sched_rd_valid,
    input  wire logic [num_channels-1:0][beats_width-1:0] sched_rd_beats,
    input  wire xfer_len_t                                cfg_xfer_beats,
    input  wire logic [num_channels-1:0][space_width-1:0] alloc_space_free,
    input  wire logic [num_channels-1:0]                  at_limit,
    output logic      [num_channels-1:0]                  arb_request,
    output xfer_len_t [num_channels-1:0]                  xfer_len
);

    // ==============================
    // Eligibility terms
    // ==============================
    logic [num_channels-1:0] space_ok;
    logic [num_channels-1:0] beats_ok;

    // Burst is the remaining count, capped at the configured size
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            if (sched_rd_beats[i] <= beats_width'(cfg_xfer_beats)) begin
                // Tail burst, fits within one configured burst
                xfer_len[i] = len_width'(sched_rd_beats[i]);
            end else begin
                xfer_len[i] = cfg_xfer_beats;
            end
        end
    end

    // Need twice the burst free
    // Covers a reservation still in flight toward the SRAM controller
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            space_ok[i] = alloc_space_free[i] >= space_width'({xfer_len[i], 1'b0});
        end
    end

    // Zero remaining means nothing to fetch even if valid is held
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            beats_ok[i] = |sched_rd_beats[i];
        end
    end

    // All four conditions gate the arbiter request
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            arb_request[i] = sched_rd_valid[i]
                           & beats_ok[i]
                           & space_ok[i]
                           & ~at_limit[i];
        end
    end

endmodule

`default_nettype wire

//--- verilog/rr_arbiter.sv
// ==============================
// Round-robin arbiter with acknowledge-gated pointer
// Grant is combinational; the pointer moves only when the grant is taken
// ==============================
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int num_channels = 4
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic [num_channels-1:0]         request,
    input  wire logic                            grant_ack,
    output logic                                 grant_valid,
    output logic [$clog2(num_channels)-1:0]      grant_id
);

    localparam int ch_width = $clog2(num_channels);

    // Channel that last won and was acknowledged
    logic [ch_width-1:0] last_id;

    // ==============================
    // Grant search
    // ==============================
    // Scan from last_id+1 around to last_id itself
    // Descending offset so the nearest requester is written last and wins
    always_comb begin : grant_search
        int idx;
        grant_valid = 1'b0;
        grant_id    = '0;
        for (int k = num_channels; k >= 1; k--) begin
            idx = (int'(last_id) + k) % num_channels;
            if (request[idx]) begin
                grant_valid = 1'b1;
                grant_id    = ch_width'(idx);
            end
        end
    end

    // ==============================
    // Pointer
    // ==============================
    // Held while the bus stalls, so an unaccepted grant keeps its priority
    always_ff @(posedge clk) begin
        if (rst) begin
            // Start just before channel 0
            last_id <= ch_width'(num_channels - 1);
        end else if (grant_ack) begin
            last_id <= grant_id;
        end
    end

    // Grant only ever goes to a live request
    // and an ack never arrives without a grant
    grant_is_requested: assert property (
        @(posedge clk) disable iff (rst)
        grant_valid |-> request[grant_id]
    );

    ack_needs_grant: assert property (
        @(posedge clk) disable iff (rst)
        grant_ack |-> grant_valid
    );

endmodule

`default_nettype wire

//--- verilog/rd_channel_tracker.sv
// ==============================
// Outstanding-burst counters and sticky read-error flags, per channel
// Counts AR issues up and last R beats down; feeds at_limit to the mask
// ==============================
`timescale 1ns/1ps
`default_nettype none

module rd_channel_tracker
    import rd_engine_pkg::*;
#(
    parameter int num_channels    = 4,
    parameter int max_outstanding = 2
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            ar_fire,
    input  wire logic [$clog2(num_channels)-1:0] ar_channel,
    input  wire logic                            r_valid,
    input  wire logic                            r_ready,
    input  wire r_beat_t                         r,
    output logic      [num_channels-1:0]         at_limit,
    output logic      [num_channels-1:0]         sched_rd_error
);

    localparam int cnt_width = $clog2(max_outstanding + 1);

    logic [num_channels-1:0][cnt_width-1:0] count;
    logic [num_channels-1:0]                incr;
    logic [num_channels-1:0]                decr;
    logic                                   r_fire;

    assign r_fire = r_valid & r_ready;

    // Decode the AR channel and the returning id
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            incr[i] = ar_fire & (ar_channel == ($clog2(num_channels))'(i));
            decr[i] = r_fire & r.last & (r.id == id_width'(i));
        end
    end

    // Up and down together leave the count alone
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            for (int i = 0; i < num_channels; i++) begin
                if (incr[i] && !decr[i]) begin
                    count[i] <= count[i] + 1'b1;
                end else if (decr[i] && !incr[i]) begin
                    count[i] <= count[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            at_limit[i] = count[i] >= cnt_width'(max_outstanding);
        end
    end

    // Sticky until reset; any non-OKAY beat marks its channel
    always_ff @(posedge clk) begin
        if (rst) begin
            sched_rd_error <= '0;
        end else begin
            for (int i = 0; i < num_channels; i++) begin
                if (r_fire && r.resp != resp_okay && r.id == id_width'(i)) begin
                    sched_rd_error[i] <= 1'b1;
                end
            end
        end
    end

    // Mask must hold issue back once a channel hits its limit
    for (genvar g = 0; g < num_channels; g++) begin : g_limit_chk
        count_in_range: assert property (
            @(posedge clk) disable iff (rst)
            count[g] <= cnt_width'(max_outstanding)
        );
    end

endmodule

`default_nettype wire

//--- verilog/ar_issue.sv
// ==============================
// AR command build and post-issue notifications
// AR is combinational from the grant; alloc and done strobes follow by 1 cycle
// ==============================
`timescale 1ns/1ps
`default_nettype none

module ar_issue
    import rd_engine_pkg::*;
#(
    parameter int num_channels = 4
) (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  wire logic                                    grant_valid,
    input  wire logic [$clog2(num_channels)-1:0]         grant_id,
    input  wire logic [num_channels-1:0][addr_width-1:0] sched_rd_addr,
    input  wire xfer_len_t [num_channels-1:0]            xfer_len,
    input  wire logic                                    ar_ready,
    output logic                                         ar_valid,
    output ar_cmd_t                                      ar,
    output logic                                         ar_fire,
    output logic                                         alloc_req,
    output alloc_req_t                                   alloc,
    output logic [num_channels-1:0]                      sched_rd_done_strobe,
    output logic [num_channels-1:0][beats_width-1:0]     sched_rd_beats_done
);

    // Burst size of the winning channel
    xfer_len_t grant_len;

    assign grant_len = xfer_len[grant_id];

    // ==============================
    // AR command
    // ==============================
    // Channel number rides in the low id bits for R routing
    assign ar_valid = grant_valid;
    assign ar.id    = id_width'(grant_id);
    assign ar.addr  = sched_rd_addr[grant_id];
    // AXI len is beats minus one
    assign ar.len   = grant_len - 1'b1;
    assign ar.size  = axi_size_code;
    assign ar.burst = axi_burst_incr;

    assign ar_fire = ar_valid & ar_ready;

    // ==============================
    // Post-issue pulses
    // ==============================
    // Single-cycle pulses, cleared by default each cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_req            <= 1'b0;
            sched_rd_done_strobe <= '0;
        end else begin
            alloc_req            <= ar_fire;
            sched_rd_done_strobe <= '0;
            if (ar_fire) begin
                sched_rd_done_strobe[grant_id] <= 1'b1;
            end
        end
    end

    // Payload loaded on AR fire and read with the pulses above
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            alloc.size                    <= grant_len;
            alloc.id                      <= id_width'(grant_id);
            sched_rd_beats_done[grant_id] <= beats_width'(grant_len);
        end
    end

    // Reservation always tracks an accepted AR one cycle back
    alloc_follows_ar: assert property (
        @(posedge clk) disable iff (rst)
        alloc_req |-> $past(ar_fire)
    );

endmodule

`default_nettype wire

//--- verilog/axi_read_engine.sv
// ==============================
// Multi-channel AXI4 read engine, top level
// Space-aware round-robin AR issue; R beats stream straight to SRAM
// ==============================
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine
    import rd_engine_pkg::*;
#(
    parameter int num_channels    = 4,
    parameter int max_outstanding = 2,
    parameter int space_width     = 8
) (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  wire xfer_len_t                               cfg_xfer_beats,
    // Scheduler side
    input  wire logic [num_channels-1:0]                 sched_rd_valid,
    input  wire logic [num_channels-1:0][addr_width-1:0] sched_rd_addr,
    input  wire logic [num_channels-1:0][beats_width-1:0] sched_rd_beats,
    output logic [num_channels-1:0]                      sched_rd_done_strobe,
    output logic [num_channels-1:0][beats_width-1:0]     sched_rd_beats_done,
    output logic [num_channels-1:0]                      sched_rd_error,
    // SRAM controller side
    output logic                                         alloc_req,
    output alloc_req_t                                   alloc,
    input  wire logic [num_channels-1:0][space_width-1:0] alloc_space_free,
    output logic                                         sram_valid,
    output r_beat_t                                      sram_beat,
    input  wire logic                                    sram_ready,
    // AXI read channels
    output logic                                         ar_valid,
    output ar_cmd_t                                      ar,
    input  wire logic                                    ar_ready,
    input  wire logic                                    r_valid,
    input  wire r_beat_t                                 r,
    output logic                                         r_ready
);

    localparam int ch_width = $clog2(num_channels);

    // Channel number must fit in the AXI id
    if (num_channels < 2 || num_channels > 16) begin : g_bad_cfg
        $error("num_channels out of range 2..16");
    end

    logic [num_channels-1:0]   arb_request;
    xfer_len_t [num_channels-1:0] xfer_len;
    logic [num_channels-1:0]   at_limit;
    logic                      grant_valid;
    logic [ch_width-1:0]       grant_id;
    logic                      ar_fire;

    rd_request_mask #(.num_channels(num_channels), .space_width(space_width)) u_mask (
        .sched_rd_valid, .sched_rd_beats, .cfg_xfer_beats, .alloc_space_free,
        .at_limit, .arb_request, .xfer_len
    );

    rr_arbiter #(.num_channels(num_channels)) u_arb (
        .clk, .rst, .request(arb_request), .grant_ack(ar_fire), .grant_valid, .grant_id
    );

    ar_issue #(.num_channels(num_channels)) u_issue (
        .clk, .rst, .grant_valid, .grant_id, .sched_rd_addr, .xfer_len, .ar_ready,
        .ar_valid, .ar, .ar_fire, .alloc_req, .alloc,
        .sched_rd_done_strobe, .sched_rd_beats_done
    );

    // Issued channel taken from the AR id the bus actually saw
    rd_channel_tracker #(
        .num_channels(num_channels), .max_outstanding(max_outstanding)
    ) u_track (
        .clk, .rst, .ar_fire, .ar_channel(ar.id[ch_width-1:0]),
        .r_valid, .r_ready, .r, .at_limit, .sched_rd_error
    );

    // ==============================
    // R path, no buffering
    // ==============================
    assign sram_valid = r_valid;
    assign sram_beat  = r;
    // SRAM back-pressure goes straight to the bus
    assign r_ready    = sram_ready;

endmodule

`default_nettype wire

//--- dv/tb_axi_read_engine.sv
// ==============================
// Self-checking testbench for the AXI4 read engine
// Drives scheduler, SRAM and AXI slave sides; concurrent assertions check
// command fields, arbitration order, strobes, limits and the R path
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_axi_read_engine
    import rd_engine_pkg::*;
();

    localparam int clk_period  = 20;
    localparam int hold_cycles = 20;
    // Beats moved by each test, used to size the run limit
    localparam int rr_beats    = 16;
    localparam int mask_beats  = 32;
    localparam int limit_beats = 10;
    localparam int bp_beats    = 64;
    localparam int cycle_limit = 30 * (rr_beats + mask_beats + limit_beats + bp_beats)
                               + hold_cycles + 200;

    logic                  clk;
    logic                  rst;
    xfer_len_t             cfg_xfer_beats;
    logic [3:0]            sched_rd_valid;
    logic [3:0][31:0]      sched_rd_addr;
    logic [3:0][31:0]      sched_rd_beats;
    logic [3:0]            sched_rd_done_strobe;
    logic [3:0][31:0]      sched_rd_beats_done;
    logic [3:0]            sched_rd_error;
    logic                  alloc_req;
    alloc_req_t            alloc;
    logic [3:0][7:0]       alloc_space_free;
    logic                  sram_valid;
    r_beat_t               sram_beat;
    logic                  sram_ready;
    logic                  ar_valid;
    ar_cmd_t               ar;
    logic                  ar_ready;
    logic                  r_valid;
    r_beat_t               r;
    logic                  r_ready;

    // Test control
    string       test_name;
    logic [15:0] lfsr;
    bit          ar_random, sram_random, rr_check, r_hold, bad_en, timed_out;
    logic [3:0]  bad_ch;
    int          assert_errors, check_errors, cycle_count;

    // Reference model state, updated on the rising edge
    bit          prev_fire;
    logic [1:0]  prev_id, last_fire_id;
    int          prev_len;
    int          tb_out [4];
    int          issue_count [4];
    logic [3:0]  err_exp;
    ar_cmd_t     pending[$];

    axi_read_engine #(
        .num_channels(4), .max_outstanding(2), .space_width(8)
    ) uut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Expected burst: remaining beats capped by the configured size
    function automatic int burst_beats(input logic [1:0] ch);
        if (sched_rd_beats[ch] < 32'(cfg_xfer_beats)) begin
            return int'(sched_rd_beats[ch]);
        end
        return int'(cfg_xfer_beats);
    endfunction

    // ==============================
    // Reference model
    // ==============================
    always @(posedge clk) begin
        if (rst) begin
            prev_fire    <= 1'b0;
            last_fire_id <= 2'd3;
            err_exp      <= '0;
            for (int c = 0; c < 4; c++) begin
                tb_out[c]      <= 0;
                issue_count[c] <= 0;
            end
        end else begin
            prev_fire <= ar_valid && ar_ready;
            if (ar_valid && ar_ready) begin
                prev_id                   <= ar.id[1:0];
                prev_len                  <= int'(ar.len) + 1;
                last_fire_id              <= ar.id[1:0];
                issue_count[ar.id[1:0]]   <= issue_count[ar.id[1:0]] + 1;
            end
            // Bursts in flight per channel, up on AR and down on last beat
            for (int c = 0; c < 4; c++) begin
                tb_out[c] <= tb_out[c]
                    + ((ar_valid && ar_ready && ar.id == 4'(c)) ? 1 : 0)
                    - ((r_valid && r_ready && r.last && r.id == 4'(c)) ? 1 : 0);
            end
            if (r_valid && r_ready && r.resp != 2'b00) begin
                err_exp[r.id[1:0]] <= 1'b1;
            end
        end
    end

    // ==============================
    // AXI slave
    // ==============================
    // In-order responder; one beat per cycle from the head command
    initial begin : axi_slave
        int beat_idx;
        r_valid  = 1'b0;
        r        = '0;
        beat_idx = 0;
        forever begin
            @(posedge clk);
            if (rst) begin
                pending.delete();
                beat_idx = 0;
            end else begin
                if (r_valid && r_ready) begin
                    if (r.last) begin
                        void'(pending.pop_front());
                        beat_idx = 0;
                    end else begin
                        beat_idx++;
                    end
                end
                if (ar_valid && ar_ready) begin
                    pending.push_back(ar);
                end
            end
            #2;
            if (pending.size() > 0 && !r_hold) begin
                r_valid = 1'b1;
                r.id    = pending[0].id;
                r.data  = {pending[0].addr, 32'(beat_idx)};
                // SLVERR on the first beat of the chosen channel
                r.resp  = (bad_en && pending[0].id == bad_ch && beat_idx == 0) ? 2'b10 : 2'b00;
                r.last  = beat_idx == int'(pending[0].len);
            end else begin
                r_valid = 1'b0;
                r       = '0;
            end
        end
    end

    // ==============================
    // Checks
    // ==============================
    ar_len_chk: assert property (@(negedge clk) disable iff (rst)
        ar_valid && ar_ready |-> int'(ar.len) + 1 == burst_beats(ar.id[1:0]))
    else begin
        assert_errors++;
        $display("Mismatch [%s] arlen+1 ch %0d: expected %0d actual %0d", test_name,
                 ar.id, burst_beats(ar.id[1:0]), int'(ar.len) + 1);
    end

    ar_addr_chk: assert property (@(negedge clk) disable iff (rst)
        ar_valid && ar_ready |-> ar.addr == sched_rd_addr[ar.id[1:0]])
    else begin
        assert_errors++;
        $display("Mismatch [%s] araddr: expected %h actual %h", test_name,
                 sched_rd_addr[ar.id[1:0]], ar.addr);
    end

    // Full 8-byte beats and INCR; id must be a channel number
    ar_fmt_chk: assert property (@(negedge clk) disable iff (rst)
        ar_valid && ar_ready |-> {ar.id[3:2], ar.size, ar.burst} == {2'b00, 3'd3, 2'b01})
    else begin
        assert_errors++;
        $display("Mismatch [%s] id_hi/size/burst: expected %h actual %h", test_name,
                 {2'b00, 3'd3, 2'b01}, {ar.id[3:2], ar.size, ar.burst});
    end

    space_chk: assert property (@(negedge clk) disable iff (rst)
        ar_valid |-> int'(alloc_space_free[ar.id[1:0]]) >= 2 * burst_beats(ar.id[1:0]))
    else begin
        assert_errors++;
        $display("Mismatch [%s] space ch %0d: expected >= %0d actual %0d", test_name,
                 ar.id, 2 * burst_beats(ar.id[1:0]), alloc_space_free[ar.id[1:0]]);
    end

    rr_chk: assert property (@(negedge clk) disable iff (rst)
        rr_check && ar_valid && ar_ready |-> ar.id[1:0] == last_fire_id + 2'd1)
    else begin
        assert_errors++;
        $display("Mismatch [%s] grant order: expected %0d actual %0d", test_name,
                 last_fire_id + 2'd1, ar.id);
    end

    alloc_chk: assert property (@(negedge clk) disable iff (rst)
        alloc_req == prev_fire
        && (!prev_fire || (int'(alloc.size) == prev_len && alloc.id == {2'b00, prev_id})))
    else begin
        assert_errors++;
        $display("Mismatch [%s] alloc req/size/id: expected %0d/%0d/%0d actual %0d/%0d/%0d",
                 test_name, prev_fire, prev_len, prev_id, alloc_req, alloc.size, alloc.id);
    end

    strobe_chk: assert property (@(negedge clk) disable iff (rst)
        sched_rd_done_strobe == (prev_fire ? 4'b0001 << prev_id : 4'b0000)
        && (!prev_fire || int'(sched_rd_beats_done[prev_id]) == prev_len))
    else begin
        assert_errors++;
        $display("Mismatch [%s] strobe/beats_done: expected %b/%0d actual %b/%0d", test_name,
                 prev_fire ? 4'b0001 << prev_id : 4'b0000, prev_len,
                 sched_rd_done_strobe, sched_rd_beats_done[prev_id]);
    end

    limit_chk: assert property (@(negedge clk) disable iff (rst)
        ar_valid && ar_ready |-> tb_out[ar.id[1:0]] < 2)
    else begin
        assert_errors++;
        $display("Mismatch [%s] bursts in flight on ch %0d: expected < 2 actual %0d",
                 test_name, ar.id, tb_out[ar.id[1:0]]);
    end

    rpath_chk: assert property (@(negedge clk)
        sram_valid == r_valid && r_ready == sram_ready && sram_beat == r)
    else begin
        assert_errors++;
        $display("Mismatch [%s] R path valid/ready/beat: expected %b/%b/%h actual %b/%b/%h",
                 test_name, r_valid, sram_ready, r, sram_valid, r_ready, sram_beat);
    end

    error_chk: assert property (@(negedge clk) disable iff (rst)
        sched_rd_error == err_exp)
    else begin
        assert_errors++;
        $display("Mismatch [%s] error flags: expected %b actual %b", test_name,
                 err_exp, sched_rd_error);
    end

    // ==============================
    // Stimulus helpers
    // ==============================
    task automatic report_and_finish();
        $display("Errors: %0d from assertions, %0d from sequence checks",
                 assert_errors, check_errors);
        if (assert_errors == 0 && check_errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // One cycle; scheduler consumes done strobes, readies are redrawn
    task automatic step();
        @(posedge clk);
        #2;
        for (int c = 0; c < 4; c++) begin
            if (sched_rd_done_strobe[c]) begin
                sched_rd_beats[c] = sched_rd_beats[c] - sched_rd_beats_done[c];
                sched_rd_addr[c]  = sched_rd_addr[c] + (sched_rd_beats_done[c] << 3);
            end
        end
        ar_ready   = ar_random ? (lfsr_bit() | lfsr_bit()) : 1'b1;
        sram_ready = sram_random ? (lfsr_bit() | lfsr_bit()) : 1'b1;
    endtask

    task automatic wait_drain(input logic [3:0] chans);
        bit busy;
        busy = 1'b1;
        while (busy) begin
            step();
            busy = pending.size() != 0;
            for (int c = 0; c < 4; c++) begin
                if (chans[c] && (sched_rd_beats[c] != 0 || tb_out[c] != 0)) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic wait_grant(input int ch, input int max_cycles);
        int start;
        bit seen;
        start = issue_count[ch];
        seen  = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++) begin
            step();
            seen = issue_count[ch] != start;
        end
        if (!seen) begin
            check_errors++;
            $display("[%s] channel %0d was not granted within %0d cycles", test_name,
                     ch, max_cycles);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            timed_out = 1'b1;
            $display("Timeout: run went past %0d cycles", cycle_limit);
            report_and_finish();
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin : stimulus
        int base;
        lfsr             = 16'd10617;
        rst              = 1'b1;
        cfg_xfer_beats   = 8'd4;
        sched_rd_valid   = '0;
        sched_rd_addr    = '0;
        sched_rd_beats   = '0;
        alloc_space_free = {4{8'd255}};
        ar_ready         = 1'b0;
        sram_ready       = 1'b0;
        {ar_random, sram_random, rr_check, r_hold, bad_en, timed_out} = '0;
        bad_ch           = '0;
        test_name        = "reset";
        repeat (4) step();
        rst = 1'b0;

        // All four eligible, single-beat bursts, bus always ready
        test_name      = "round_robin";
        cfg_xfer_beats = 8'd1;
        for (int c = 0; c < 4; c++) begin
            sched_rd_addr[c]  = rand_bits(29) << 3;
            sched_rd_beats[c] = 32'd4;
        end
        sched_rd_valid = 4'b1111;
        rr_check       = 1'b1;
        wait_drain(4'b1111);
        rr_check = 1'b0;

        // Channel 2 starved of space until the others finish
        test_name           = "space_mask";
        cfg_xfer_beats      = 8'd4;
        alloc_space_free[2] = 8'd7;
        for (int c = 0; c < 4; c++) begin
            sched_rd_beats[c] = 32'd8;
        end
        {ar_random, sram_random} = 2'b11;
        wait_drain(4'b1011);
        if (sched_rd_beats[2] != 32'd8) begin
            check_errors++;
            $display("Mismatch [%s] ch 2 beats left while masked: expected 8 actual %0d",
                     test_name, sched_rd_beats[2]);
        end
        alloc_space_free[2] = 8'd8;
        wait_grant(2, 50);
        wait_drain(4'b0100);

        // R held back; channel 1 must stop at two bursts, with a bad beat
        test_name                = "outstanding";
        {ar_random, sram_random} = 2'b00;
        cfg_xfer_beats           = 8'd2;
        sched_rd_valid           = 4'b0010;
        sched_rd_beats[1]        = 32'd10;
        {r_hold, bad_en}         = 2'b11;
        bad_ch                   = 4'd1;
        base                     = issue_count[1];
        repeat (hold_cycles) step();
        if (issue_count[1] - base != 2) begin
            check_errors++;
            $display("Mismatch [%s] bursts issued while held: expected 2 actual %0d",
                     test_name, issue_count[1] - base);
        end
        r_hold = 1'b0;
        wait_grant(1, 30);
        wait_drain(4'b0010);

        // Random lengths and addresses under random back-pressure
        test_name      = "back_pressure";
        cfg_xfer_beats = 8'd4;
        bad_ch         = 4'd3;
        for (int c = 0; c < 4; c++) begin
            sched_rd_addr[c]  = rand_bits(29) << 3;
            sched_rd_beats[c] = rand_bits(4) + 32'd1;
        end
        sched_rd_valid           = 4'b1111;
        {ar_random, sram_random} = 2'b11;
        wait_drain(4'b1111);
        repeat (4) step();
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- project.f
verilog/rd_engine_pkg.sv
verilog/rd_request_mask.sv
verilog/rr_arbiter.sv
verilog/rd_channel_tracker.sv
verilog/ar_issue.sv
verilog/axi_read_engine.sv
dv/tb_axi_read_engine.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI read engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_axi_read_engine -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
